// File: design/rv_alu_op_decode.sv
`default_nettype none

module rv_alu_op_decode
    import rv_isa_pkg::*;
    import rv_decode_pkg::*;
(
    input  instr_t   instr,
    output alu_dec_t alu
);

    opcode_t opcode;
    funct3_t funct3;
    funct7_t funct7;
    logic    f7_base;
    logic    f7_alt;
    alu_op_e op;      // Raw pick before the illegal override
    logic    bad;

    assign opcode  = instr[6:0];
    assign funct3  = instr[14:12];
    assign funct7  = instr[31:25];  // Raw field, even for I-type shifts
    assign f7_base = (funct7 == F7_BASE);
    assign f7_alt  = (funct7 == F7_ALT);

    always_comb begin
        op  = ALU_NONE;
        bad = 1'b0;
        case (opcode)
            OPC_OP: begin
                case (funct3)
                    F3_ADD_SUB: op = f7_alt ? ALU_SUB : ALU_ADD;
                    F3_AND:     op = ALU_AND;
                    F3_OR:      op = ALU_OR;
                    F3_XOR:     op = ALU_XOR;
                    F3_SLL:     op = ALU_SLL;
                    F3_SRL_SRA: op = f7_alt ? ALU_SRA : ALU_SRL;
                    default:    bad = 1'b1;  // SLT/SLTU not in this subset
                endcase
                // Only ADD/SUB and SRL/SRA have an ALT form
                if (funct3 == F3_ADD_SUB || funct3 == F3_SRL_SRA)
                    bad = bad || !(f7_base || f7_alt);
                else
                    bad = bad || !f7_base;
            end
            OPC_OP_IMM: begin
                case (funct3)
                    F3_ADD_SUB: op = ALU_ADD;
                    F3_AND:     op = ALU_AND;
                    F3_OR:      op = ALU_OR;
                    F3_XOR:     op = ALU_XOR;
                    F3_SLL:     op = ALU_SLL;
                    F3_SLTU:    op = ALU_SLTU;
                    F3_SRL_SRA: begin
                        op  = f7_alt ? ALU_SRA : ALU_SRL;
                        bad = !(f7_base || f7_alt);
                    end
                    default:    bad = 1'b1;  // SLTI
                endcase
            end
            OPC_OP_IMM_32: begin
                case (funct3)
                    F3_ADD_SUB: op = ALU_ADD;  // ADDIW
                    F3_SLL:     op = ALU_SLL;
                    F3_SRL_SRA: begin
                        op  = f7_alt ? ALU_SRA : ALU_SRL;
                        bad = !(f7_base || f7_alt);
                    end
                    default:    bad = 1'b1;
                endcase
            end
            OPC_LOAD: begin
                op  = ALU_ADD;  // Address = rs1 + imm
                bad = !(funct3 == F3_LD || funct3 == F3_LW || funct3 == F3_LBU);
            end
            OPC_STORE: begin
                op  = ALU_ADD;
                bad = !(funct3 == F3_SB || funct3 == F3_SH ||
                        funct3 == F3_SW || funct3 == F3_SD);
            end
            OPC_BRANCH: begin
                case (funct3)
                    F3_BEQ:  op = ALU_EQ;
                    F3_BNE:  op = ALU_NE;
                    F3_BLT:  op = ALU_LT;
                    F3_BGE:  op = ALU_GE;
                    F3_BLTU: op = ALU_LTU;
                    F3_BGEU: op = ALU_GEU;
                    default: bad = 1'b1;  // 010 and 011 unused
                endcase
            end
            OPC_JALR:  op = ALU_ADD;   // Target address
            OPC_LUI:   op = ALU_NONE;  // Immediate passes through
            OPC_AUIPC: op = ALU_ADD;   // pc + imm
            OPC_JAL:   op = ALU_JUMP;
            default:   bad = 1'b1;
        endcase
    end

    // Illegal words never carry an operation
    assign alu.alu_op  = bad ? ALU_NONE : op;
    assign alu.illegal = bad;

endmodule

`default_nettype wire

// File: design/rv_decode_merge.sv
`default_nettype none

module rv_decode_merge
    import rv_isa_pkg::*;
    import rv_decode_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     in_valid,
    output logic     in_ready,
    input  instr_t   in_instr,
    input  imm_t     imm,       // From rv_imm_gen
    input  alu_dec_t alu,       // From rv_alu_op_decode
    output logic     out_valid,
    input  logic     out_ready,
    output decoded_t out_dec
);

    opcode_t  opcode;
    decoded_t next_dec;  // Record to load on a transfer
    logic     accept;

    assign opcode = in_instr[6:0];

    always_comb begin
        // Raw split, same positions for every format
        next_dec.rs1     = in_instr[19:15];
        next_dec.rs2     = in_instr[24:20];
        next_dec.rd      = in_instr[11:7];
        next_dec.opcode  = opcode;
        next_dec.funct3  = in_instr[14:12];
        next_dec.funct7  = in_instr[31:25];
        next_dec.imm     = imm;
        next_dec.alu_op  = alu.alu_op;
        next_dec.illegal = alu.illegal;

        // Clear what the format does not use
        case (opcode)
            OPC_LUI,
            OPC_AUIPC,
            OPC_JAL: begin
                next_dec.rs1    = '0;
                next_dec.rs2    = '0;
                next_dec.funct3 = '0;
                next_dec.funct7 = '0;
            end
            OPC_OP_IMM,
            OPC_OP_IMM_32,
            OPC_JALR,
            OPC_LOAD: begin
                next_dec.rs2    = '0;  // Bits hold the immediate
                next_dec.funct7 = '0;
            end
            OPC_STORE,
            OPC_BRANCH: begin
                next_dec.rd     = '0;  // No destination
                next_dec.funct7 = '0;
            end
            default: ;  // R-type and unknown opcodes keep everything
        endcase
    end

    // Empty slot or downstream draining this cycle
    assign in_ready = !out_valid || out_ready;
    assign accept   = in_valid && in_ready;

    always_ff @(posedge clk) begin
        if (!rst_n)
            out_valid <= 1'b0;
        else if (in_ready)
            out_valid <= in_valid;  // Refill or go empty
    end

    always_ff @(posedge clk) begin
        if (accept)
            out_dec <= next_dec;
    end

endmodule

`default_nettype wire

// File: design/rv_decode_pkg.sv
`default_nettype none

package rv_decode_pkg;

    import rv_isa_pkg::*;

    // 17 distinct operations need 5 bits
    localparam int ALU_OP_W = 5;

    typedef enum logic [ALU_OP_W-1:0] {
        ALU_NONE = 5'd0,   // LUI and every illegal word
        ALU_ADD  = 5'd1,
        ALU_SUB  = 5'd2,
        ALU_AND  = 5'd3,
        ALU_OR   = 5'd4,
        ALU_XOR  = 5'd5,
        ALU_SLL  = 5'd6,
        ALU_SRL  = 5'd7,
        ALU_SRA  = 5'd8,
        ALU_SLTU = 5'd9,
        ALU_EQ   = 5'd10,  // Branch compares
        ALU_NE   = 5'd11,
        ALU_LT   = 5'd12,
        ALU_GE   = 5'd13,
        ALU_LTU  = 5'd14,
        ALU_GEU  = 5'd15,
        ALU_JUMP = 5'd16   // JAL
    } alu_op_e;

    typedef struct packed {
        xlen_t imm_signed;
        xlen_t imm_unsigned;  // Branch offset only
    } imm_t;

    typedef struct packed {
        alu_op_e alu_op;
        logic    illegal;
    } alu_dec_t;

    // One decoded instruction as it leaves the stage
    typedef struct packed {
        reg_idx_t rs1;
        reg_idx_t rs2;
        reg_idx_t rd;
        opcode_t  opcode;
        funct3_t  funct3;
        funct7_t  funct7;
        imm_t     imm;
        alu_op_e  alu_op;
        logic     illegal;
    } decoded_t;

endpackage

`default_nettype wire

// File: design/rv_decoder_top.sv
`default_nettype none

module rv_decoder_top
    import rv_isa_pkg::*;
    import rv_decode_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    // Instruction stream in
    input  logic     in_valid,
    output logic     in_ready,
    input  instr_t   in_instr,
    // Decoded records out
    output logic     out_valid,
    input  logic     out_ready,
    output decoded_t out_dec
);

    imm_t     imm;  // Immediates of the word at the input
    alu_dec_t alu;

    // Both decoders look at the same input word
    rv_imm_gen u_imm_gen (
        .instr (in_instr),
        .imm   (imm)
    );

    rv_alu_op_decode u_alu_op_decode (
        .instr (in_instr),
        .alu   (alu)
    );

    // Field split, zeroing and the output register
    rv_decode_merge u_decode_merge (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_instr  (in_instr),
        .imm       (imm),
        .alu       (alu),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_dec   (out_dec)
    );

endmodule

`default_nettype wire

// File: design/rv_imm_gen.sv
`default_nettype none

module rv_imm_gen
    import rv_isa_pkg::*;
    import rv_decode_pkg::*;
(
    input  instr_t instr,
    output imm_t   imm
);

    opcode_t     opcode;
    logic        sign;
    logic [11:0] i_imm;  // I-type raw field
    logic [11:0] s_imm;  // Split S-type field
    logic [12:0] b_off;  // Branch offset, LSB always zero
    logic [19:0] u_imm;
    logic [20:0] j_off;  // JAL offset, LSB always zero

    assign opcode = instr[6:0];
    assign sign   = instr[IMM_SIGN_BIT];

    // Bit scrambles per format
    assign i_imm = instr[31:20];
    assign s_imm = {instr[31:25], instr[11:7]};
    assign b_off = {sign, instr[7], instr[30:25], instr[11:8], 1'b0};
    assign u_imm = instr[31:12];
    assign j_off = {sign, instr[19:12], instr[20], instr[30:21], 1'b0};

    always_comb begin
        imm = '0;  // R-type and unknown opcodes carry no immediate
        case (opcode)
            OPC_OP_IMM,
            OPC_OP_IMM_32,
            OPC_JALR,
            OPC_LOAD: begin
                imm.imm_signed = {{(XLEN-12){sign}}, i_imm};
            end
            OPC_STORE: begin
                imm.imm_signed = {{(XLEN-12){sign}}, s_imm};
            end
            OPC_BRANCH: begin
                imm.imm_signed   = {{(XLEN-13){sign}}, b_off};
                // Zero extended copy for the unsigned compares
                imm.imm_unsigned = {{(XLEN-13){1'b0}}, b_off};
            end
            OPC_LUI,
            OPC_AUIPC: begin
                imm.imm_signed = {u_imm, 12'b0};  // Upper 20 bits, low 12 clear
            end
            OPC_JAL: begin
                imm.imm_signed = {{(XLEN-21){sign}}, j_off};
            end
            default: begin
                imm = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: design/rv_isa_pkg.sv
`default_nettype none

package rv_isa_pkg;

    // Field widths fixed by the base ISA
    localparam int INSTR_W      = 32;
    localparam int REG_IDX_W    = 5;
    localparam int OPCODE_W     = 7;
    localparam int FUNCT3_W     = 3;
    localparam int FUNCT7_W     = 7;
    localparam int XLEN         = 32;  // Immediate width as carried in the record
    localparam int IMM_SIGN_BIT = 31;  // Same sign bit for I, S, B, U and J

    typedef logic [INSTR_W-1:0]   instr_t;
    typedef logic [REG_IDX_W-1:0] reg_idx_t;
    typedef logic [OPCODE_W-1:0]  opcode_t;
    typedef logic [FUNCT3_W-1:0]  funct3_t;
    typedef logic [FUNCT7_W-1:0]  funct7_t;
    typedef logic [XLEN-1:0]      xlen_t;

    // Major opcodes
    localparam opcode_t OPC_OP        = 7'b0110011;  // R-type
    localparam opcode_t OPC_OP_IMM    = 7'b0010011;
    localparam opcode_t OPC_OP_IMM_32 = 7'b0011011;  // RV64 word ops
    localparam opcode_t OPC_JALR      = 7'b1100111;
    localparam opcode_t OPC_LOAD      = 7'b0000011;
    localparam opcode_t OPC_STORE     = 7'b0100011;
    localparam opcode_t OPC_BRANCH    = 7'b1100011;
    localparam opcode_t OPC_LUI       = 7'b0110111;
    localparam opcode_t OPC_AUIPC     = 7'b0010111;
    localparam opcode_t OPC_JAL       = 7'b1101111;

    localparam funct7_t F7_BASE = 7'b0000000;
    localparam funct7_t F7_ALT  = 7'b0100000;  // SUB / SRA select

    // Integer ops, shared by OP, OP-IMM and OP-IMM-32
    localparam funct3_t F3_ADD_SUB = 3'b000;
    localparam funct3_t F3_SLL     = 3'b001;
    localparam funct3_t F3_SLTU    = 3'b011;
    localparam funct3_t F3_XOR     = 3'b100;
    localparam funct3_t F3_SRL_SRA = 3'b101;
    localparam funct3_t F3_OR      = 3'b110;
    localparam funct3_t F3_AND     = 3'b111;

    // Loads
    localparam funct3_t F3_LW  = 3'b010;
    localparam funct3_t F3_LD  = 3'b011;
    localparam funct3_t F3_LBU = 3'b100;

    // Stores
    localparam funct3_t F3_SB = 3'b000;
    localparam funct3_t F3_SH = 3'b001;
    localparam funct3_t F3_SW = 3'b010;
    localparam funct3_t F3_SD = 3'b011;

    // Branches
    localparam funct3_t F3_BEQ  = 3'b000;
    localparam funct3_t F3_BNE  = 3'b001;
    localparam funct3_t F3_BLT  = 3'b100;
    localparam funct3_t F3_BGE  = 3'b101;
    localparam funct3_t F3_BLTU = 3'b110;
    localparam funct3_t F3_BGEU = 3'b111;

endpackage

`default_nettype wire

// File: project.f
design/rv_isa_pkg.sv
design/rv_decode_pkg.sv
design/rv_imm_gen.sv
design/rv_alu_op_decode.sv
design/rv_decode_merge.sv
design/rv_decoder_top.sv
verif/tb_rv_decoder.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the decoder testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --assert --timescale 1ns/100ps \
    -f project.f --top-module tb_rv_decoder \
    -Mdir "$BUILD_DIR" -o sim_tb
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$BUILD_DIR/sim_tb" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"

if grep -q "Result: FAILED" "$LOG"; then
    echo "Simulation reported a failure"
    exit 1
fi

if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

exit 0

// File: verif/tb_rv_decoder.sv
`default_nettype none

module tb_rv_decoder
    import rv_isa_pkg::*;
    import rv_decode_pkg::*;
;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int TIMEOUT = 64;        // Cycles any wait may take
    localparam int RAND_WORDS = 400;

    logic     clk;
    logic     rst_n;
    logic     in_valid;
    logic     in_ready;
    instr_t   in_instr;
    logic     out_valid;
    logic     out_ready;
    decoded_t out_dec;

    decoded_t    exp_q[$];              // Records in flight, oldest first
    decoded_t    held_dec;
    logic        stalled;               // Back-pressure seen at the last negedge
    logic        bp_random;             // Random out_ready when set
    logic [31:0] word_state = 32'hb60a;
    logic [31:0] bp_state;
    int          cycles;
    int          accepted;
    int          delivered;

    // Ten legal opcodes, then two that decode to nothing
    opcode_t opcodes[12] = '{OPC_OP, OPC_OP_IMM, OPC_OP_IMM_32, OPC_JALR, OPC_LOAD,
                             OPC_STORE, OPC_BRANCH, OPC_LUI, OPC_AUIPC, OPC_JAL,
                             7'b1111111, 7'b0000000};
    funct7_t f7_list[3] = '{F7_BASE, F7_ALT, 7'h01};

    rv_decoder_top DUT (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_instr  (in_instr),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_dec   (out_dec)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) cycles <= cycles + 1;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] next_word_rand();
        word_state = xorshift(word_state);
        return word_state;
    endfunction

    task automatic stop_run();
        $display("Result: FAILED");
        $fatal(1);
    endtask

    task automatic report_error(input string what);
        $display("error at %0t ns: %s", $time, what);
        stop_run();
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] exp,
                                   input logic [31:0] got);
        $display("mismatch at %0t ns: %s expected %h got %h", $time, name, exp, got);
        stop_run();
    endtask

    task automatic check_field(input string name, input logic [31:0] exp,
                               input logic [31:0] got);
        assert (exp == got) else report_mismatch(name, exp, got);
    endtask

    task automatic check_record(input string tag, input decoded_t exp, input decoded_t got);
        check_field({tag, ".rs1"}, 32'(exp.rs1), 32'(got.rs1));
        check_field({tag, ".rs2"}, 32'(exp.rs2), 32'(got.rs2));
        check_field({tag, ".rd"}, 32'(exp.rd), 32'(got.rd));
        check_field({tag, ".opcode"}, 32'(exp.opcode), 32'(got.opcode));
        check_field({tag, ".funct3"}, 32'(exp.funct3), 32'(got.funct3));
        check_field({tag, ".funct7"}, 32'(exp.funct7), 32'(got.funct7));
        check_field({tag, ".imm_signed"}, exp.imm.imm_signed, got.imm.imm_signed);
        check_field({tag, ".imm_unsigned"}, exp.imm.imm_unsigned, got.imm.imm_unsigned);
        check_field({tag, ".alu_op"}, 32'(exp.alu_op), 32'(got.alu_op));
        check_field({tag, ".illegal"}, 32'(exp.illegal), 32'(got.illegal));
    endtask

    // Expected record straight from the ISA rules
    function automatic decoded_t model_decode(input instr_t w);
        decoded_t    d;
        funct3_t     f3;
        funct7_t     f7;
        logic        f7_ok;
        logic [12:0] b_off;
        logic [20:0] j_off;
        logic [31:0] i_ext;   // Bits 31:20 with sign
        f3    = w[14:12];
        f7    = w[31:25];
        f7_ok = (f7 == F7_BASE) || (f7 == F7_ALT);
        b_off = {w[31], w[7], w[30:25], w[11:8], 1'b0};
        j_off = {w[31], w[19:12], w[20], w[30:21], 1'b0};
        i_ext = $signed(w) >>> 20;
        d = '0;
        {d.funct7, d.rs2, d.rs1, d.funct3, d.rd, d.opcode} = w;
        case (w[6:0])
            OPC_OP: begin
                case (f3)
                    3'b000: d.alu_op = (f7 == F7_ALT) ? ALU_SUB : ALU_ADD;
                    3'b101: d.alu_op = (f7 == F7_ALT) ? ALU_SRA : ALU_SRL;
                    3'b111: d.alu_op = ALU_AND;
                    3'b110: d.alu_op = ALU_OR;
                    3'b100: d.alu_op = ALU_XOR;
                    3'b001: d.alu_op = ALU_SLL;
                    default: d.illegal = 1'b1;
                endcase
                if (f3 == 3'b000 || f3 == 3'b101)
                    d.illegal = d.illegal | !f7_ok;
                else
                    d.illegal = d.illegal | (f7 != F7_BASE);
            end
            OPC_OP_IMM: begin
                case (f3)
                    3'b000: d.alu_op = ALU_ADD;
                    3'b111: d.alu_op = ALU_AND;
                    3'b110: d.alu_op = ALU_OR;
                    3'b100: d.alu_op = ALU_XOR;
                    3'b001: d.alu_op = ALU_SLL;
                    3'b011: d.alu_op = ALU_SLTU;
                    3'b101: d.alu_op = (f7 == F7_ALT) ? ALU_SRA : ALU_SRL;
                    default: d.illegal = 1'b1;
                endcase
                d.illegal = d.illegal | (f3 == 3'b101 && !f7_ok);
            end
            OPC_OP_IMM_32: begin
                case (f3)
                    3'b000: d.alu_op = ALU_ADD;
                    3'b001: d.alu_op = ALU_SLL;
                    3'b101: d.alu_op = (f7 == F7_ALT) ? ALU_SRA : ALU_SRL;
                    default: d.illegal = 1'b1;
                endcase
                d.illegal = d.illegal | (f3 == 3'b101 && !f7_ok);
            end
            OPC_LOAD: begin
                d.alu_op  = ALU_ADD;
                d.illegal = !(f3 inside {3'b010, 3'b011, 3'b100});
            end
            OPC_STORE: begin
                d.alu_op  = ALU_ADD;
                d.illegal = f3[2];  // Only byte to double stores
            end
            OPC_BRANCH: begin
                case (f3)
                    3'b000: d.alu_op = ALU_EQ;
                    3'b001: d.alu_op = ALU_NE;
                    3'b100: d.alu_op = ALU_LT;
                    3'b101: d.alu_op = ALU_GE;
                    3'b110: d.alu_op = ALU_LTU;
                    3'b111: d.alu_op = ALU_GEU;
                    default: d.illegal = 1'b1;
                endcase
            end
            OPC_JALR, OPC_AUIPC: d.alu_op = ALU_ADD;
            OPC_LUI:             d.alu_op = ALU_NONE;
            OPC_JAL:             d.alu_op = ALU_JUMP;
            default:             d.illegal = 1'b1;
        endcase
        if (d.illegal)
            d.alu_op = ALU_NONE;

        // Immediate and unused fields per format
        case (w[6:0])
            OPC_OP_IMM, OPC_OP_IMM_32, OPC_JALR, OPC_LOAD: begin
                d.imm.imm_signed = i_ext;
                {d.rs2, d.funct7} = '0;
            end
            OPC_STORE: begin
                d.imm.imm_signed = {i_ext[31:5], w[11:7]};
                {d.rd, d.funct7} = '0;
            end
            OPC_BRANCH: begin
                d.imm.imm_signed   = $signed({b_off, 19'b0}) >>> 19;
                d.imm.imm_unsigned = {19'b0, b_off};
                {d.rd, d.funct7} = '0;
            end
            OPC_LUI, OPC_AUIPC, OPC_JAL: begin
                if (w[6:0] == OPC_JAL)
                    d.imm.imm_signed = $signed({j_off, 11'b0}) >>> 11;
                else
                    d.imm.imm_signed = w & 32'hfffff000;
                {d.rs1, d.rs2, d.funct3, d.funct7} = '0;
            end
            default: ;
        endcase
        return d;
    endfunction

    // Mid-cycle monitor, everything is settled at the falling edge
    always @(negedge clk) begin
        if (rst_n) begin
            assert (exp_q.size() <= 1) else report_error("more than one record pending");
            assert (out_valid == (exp_q.size() != 0))
            else report_mismatch("out_valid", 32'(exp_q.size() != 0), 32'(out_valid));
            if (stalled) begin
                assert (out_valid) else report_error("out_valid dropped under back-pressure");
                check_record("held out_dec", held_dec, out_dec);
            end
            if (out_valid)
                check_record("out_dec", exp_q[0], out_dec);
            // Ready whenever the model holds nothing or the sink drains
            assert (in_ready == (exp_q.size() == 0 || out_ready))
            else report_mismatch("in_ready", 32'(exp_q.size() == 0 || out_ready),
                                 32'(in_ready));
            stalled  = out_valid && !out_ready;
            held_dec = out_dec;
            if (out_valid && out_ready) begin
                void'(exp_q.pop_front());
                delivered++;
            end
            if (in_valid && in_ready) begin
                exp_q.push_back(model_decode(in_instr));
                accepted++;
            end
        end else begin
            stalled = 1'b0;
        end
    end

    always @(posedge clk) begin
        #1;
        if (bp_random) begin
            bp_state  = xorshift(bp_state);
            out_ready = bp_state[3];
        end
    end

    // Called 1 ns after a rising edge, returns 1 ns after the accepting edge
    task automatic send_word(input instr_t w);
        int waited;
        waited   = 0;
        in_valid = 1'b1;
        in_instr = w;
        @(negedge clk);
        while (!in_ready) begin
            waited++;
            if (waited > TIMEOUT)
                report_error("in_ready stayed low, input handshake timed out");
            @(negedge clk);
        end
        @(posedge clk);
        #1;
        in_valid = 1'b0;
    endtask

    // Returns 1 ns after a rising edge, ready for the next drive
    task automatic wait_drain();
        int waited;
        waited = 0;
        while (exp_q.size() != 0) begin
            waited++;
            if (waited > TIMEOUT)
                report_error("records never left the output register");
            @(negedge clk);
        end
        @(posedge clk);
        #1;
    endtask

    // Legal opcodes most of the time, funct7 leaning to BASE and ALT
    function automatic instr_t make_word();
        logic [31:0] r;
        logic [31:0] s;
        opcode_t     opc;
        funct7_t     f7;
        r   = next_word_rand();
        s   = next_word_rand();
        opc = (r[4:0] < 5'd30) ? opcodes[int'(r[4:0]) % 10] : s[6:0];
        case (r[6:5])
            2'd0, 2'd1: f7 = F7_BASE;
            2'd2:       f7 = F7_ALT;
            default:    f7 = s[31:25];
        endcase
        return {f7, s[24:7], opc};
    endfunction

    initial begin
        int      start;
        int      n_words;
        logic [31:0] r;
        rst_n     = 1'b0;
        in_valid  = 1'b0;
        in_instr  = '0;
        out_ready = 1'b0;
        bp_random = 1'b0;
        bp_state  = xorshift(32'hb60a);
        stalled   = 1'b0;
        held_dec  = '0;
        cycles    = 0;
        accepted  = 0;
        delivered = 0;
        repeat (4) @(posedge clk);
        #1;
        rst_n = 1'b1;
        @(negedge clk);
        assert (!out_valid) else report_error("out_valid high after reset");
        assert (in_ready) else report_error("in_ready low after reset");
        @(posedge clk);
        #1;

        // Every opcode, funct3 and funct7 class back to back
        out_ready = 1'b1;
        start     = cycles;
        n_words   = 0;
        for (int i = 0; i < 12; i++) begin
            for (int j = 0; j < 8; j++) begin
                for (int k = 0; k < 3; k++) begin
                    r = next_word_rand();
                    send_word({f7_list[k], r[24:15], 3'(j), r[11:7], opcodes[i]});
                    n_words++;
                end
            end
        end
        assert (cycles - start == n_words)
        else report_mismatch("burst cycles", 32'(n_words), 32'(cycles - start));
        wait_drain();
        check_field("delivered", 32'(n_words), 32'(delivered));

        // Random words, idle gaps and back-pressure
        bp_random = 1'b1;
        for (int i = 0; i < RAND_WORDS; i++) begin
            r = next_word_rand();
            if (r[2:0] == 3'd0) begin
                @(posedge clk);
                #1;
            end
            send_word(make_word());
        end
        bp_random = 1'b0;
        out_ready = 1'b1;
        wait_drain();

        if (delivered != accepted || accepted != n_words + RAND_WORDS) begin
            report_error("records lost or duplicated");
        end else begin
            $display("Result: PASSED");
            $finish;
        end
    end

endmodule

`default_nettype wire
